/* Makefile */
# Verilator build and run of the stream multiplexer testbench.
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_smux -f src.f -Mdir $(OBJ_DIR) -o sim_smux
	./$(OBJ_DIR)/sim_smux +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/at_buffer.sv */
// Four-phase receiver for AT characters feeding an 8-deep circular FIFO.
module at_buffer
(
	input  logic clock,
	input  logic resetn,
	input  logic at_req_i,
	input  logic [smux_pkg::AT_W-1:0] at_data_i,
	output logic at_ack_o,
	grant_if.cmd_source cmd
);

	logic [smux_pkg::AT_W-1:0] mem [smux_pkg::AT_DEPTH];
	// One extra bit tells full from empty.
	logic [smux_pkg::AT_PTR_W:0] wr_ptr;
	logic [smux_pkg::AT_PTR_W:0] rd_ptr;
	logic fifo_full;
	logic fifo_empty;
	logic accept;
	logic ack_q;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr[smux_pkg::AT_PTR_W] != rd_ptr[smux_pkg::AT_PTR_W])
		&& (wr_ptr[smux_pkg::AT_PTR_W-1:0] == rd_ptr[smux_pkg::AT_PTR_W-1:0]);
	assign accept = at_req_i && !fifo_full && !ack_q;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			ack_q <= 1'b0;
		end
		else
		begin
			if (accept)
			begin
				wr_ptr <= wr_ptr + 1'b1;
				ack_q <= 1'b1;
			end
			else if (!at_req_i)
			begin
				ack_q <= 1'b0;
			end

			if (cmd.at_pop && !fifo_empty)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			mem[wr_ptr[smux_pkg::AT_PTR_W-1:0]] <= at_data_i;
		end
	end

	assign at_ack_o = ack_q;
	assign cmd.at_empty = fifo_empty;
	assign cmd.at_char = mem[rd_ptr[smux_pkg::AT_PTR_W-1:0]];

endmodule

/* design/frame_sender.sv */
// Frame builder and four-phase output port.
module frame_sender
(
	input  logic clock,
	input  logic resetn,
	grant_if.sender grant,
	bank_if.reader bank,
	output logic frame_req_o,
	output logic [smux_pkg::FRAME_W-1:0] frame_o,
	input  logic frame_ack_i
);

	typedef enum logic [1:0] {TX_IDLE, TX_WAIT_ACK, TX_WAIT_RELEASE} tx_state_t;

	tx_state_t tx_state;
	smux_pkg::frame_t next_frame;
	smux_pkg::frame_t frame_q;
	logic start;

	assign start = (tx_state == TX_IDLE) && grant.grant_valid;

	// Fill the view that matches the granted source.
	always_comb
	begin
		next_frame = '0;
		if (grant.grant_at)
		begin
			next_frame.cmd.kind = smux_pkg::KIND_CMD;
			next_frame.cmd.pad = '0;
			next_frame.cmd.character = grant.at_char;
		end
		else
		begin
			next_frame.data.kind = smux_pkg::KIND_DATA;
			next_frame.data.index = grant.grant_index;
			next_frame.data.sample = bank.samples[grant.grant_index];
		end
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			tx_state <= TX_IDLE;
			frame_req_o <= 1'b0;
		end
		else
		begin
			case (tx_state)
				TX_IDLE:
				begin
					if (start)
					begin
						frame_req_o <= 1'b1;
						tx_state <= TX_WAIT_ACK;
					end
				end
				TX_WAIT_ACK:
				begin
					if (frame_ack_i)
					begin
						frame_req_o <= 1'b0;
						tx_state <= TX_WAIT_RELEASE;
					end
				end
				TX_WAIT_RELEASE:
				begin
					if (!frame_ack_i)
						tx_state <= TX_IDLE;
				end
				default:
					tx_state <= TX_IDLE;
			endcase
		end
	end

	// Frame is held for the whole handshake.
	always_ff @(posedge clock)
	begin
		if (start)
			frame_q <= next_frame;
	end

	assign frame_o = frame_q;
	assign bank.pop = start && !grant.grant_at;
	assign bank.pop_index = grant.grant_index;
	assign grant.at_pop = start && grant.grant_at;
	assign grant.word_done = (tx_state == TX_WAIT_RELEASE) && !frame_ack_i;

endmodule

/* design/slot_scheduler.sv */
// Rotating slot scheduler with AT drain mode.
// Slot timer, rotating enable mask and stream index.
module slot_scheduler
(
	input  logic clock,
	input  logic resetn,
	input  logic sending_i,
	input  logic want_at_i,
	input  logic [smux_pkg::NUM_STREAMS-1:0] selected_streams_i,
	input  logic [smux_pkg::TIMER_W-1:0] slot_cycles_i,
	bank_if.viewer bank,
	grant_if.scheduler grant
);

	typedef enum logic [2:0] {ST_IDLE, ST_AT, ST_LOAD, ST_FIND, ST_RUN} state_t;

	state_t state;
	state_t next_state;
	logic [smux_pkg::TIMER_W-1:0] timer;
	logic [smux_pkg::NUM_STREAMS-1:0] mask;
	logic [smux_pkg::IDX_W-1:0] index;
	logic timer_done;
	logic end_slot;
	logic advance;
	logic last_index;
	logic in_flight;
	logic grant_valid;

	// ----------------------------------------
	// Slot timer and rotation
	// ----------------------------------------
	assign timer_done = (timer == slot_cycles_i);
	// A slot ends only between frames.
	assign end_slot = (state == ST_RUN) && timer_done && !in_flight;
	assign advance = ((state == ST_FIND) && !mask[0]) || end_slot;
	assign last_index = (index == smux_pkg::IDX_W'(smux_pkg::NUM_STREAMS - 1));

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			timer <= '0;
			mask <= '0;
			index <= '0;
			in_flight <= 1'b0;
		end
		else
		begin
			// Timer holds while a frame handshake is open.
			if (state != ST_RUN)
				timer <= '0;
			else if (!in_flight && !timer_done)
				timer <= timer + 1'b1;

			if (state == ST_LOAD)
				mask <= selected_streams_i;
			else if (advance)
				mask <= {mask[0], mask[smux_pkg::NUM_STREAMS-1:1]};

			if (state == ST_IDLE)
				index <= '0;
			else if (advance)
				index <= index + 1'b1;

			// Mirrors the sender: busy from a granted start until word_done.
			if (grant.word_done)
				in_flight <= 1'b0;
			else if (grant_valid)
				in_flight <= 1'b1;
		end
	end

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
			begin
				if (sending_i && want_at_i && !grant.at_empty)
					next_state = ST_AT;
				else if (sending_i)
					next_state = ST_LOAD;
			end
			ST_AT:
			begin
				if (grant.at_empty && !in_flight)
					next_state = ST_IDLE;
			end
			ST_LOAD:
				next_state = ST_FIND;
			ST_FIND:
			begin
				// A finished rotation goes back through Idle to relatch the mask.
				if (!sending_i)
					next_state = ST_IDLE;
				else if (mask[0])
					next_state = ST_RUN;
				else if (last_index)
					next_state = ST_IDLE;
			end
			ST_RUN:
			begin
				if (end_slot)
					next_state = last_index ? ST_IDLE : ST_FIND;
			end
			default:
				next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// Valid means the owner has a word ready and a new frame may start.
	always_comb
	begin
		grant_valid = 1'b0;
		if (state == ST_AT)
			grant_valid = sending_i && !grant.at_empty;
		else if (state == ST_RUN)
			grant_valid = sending_i && bank.full[index] && !timer_done;
	end

	assign grant.grant_valid = grant_valid;
	assign grant.grant_at = (state == ST_AT);
	assign grant.grant_index = index;

endmodule

/* design/smux_ifs.sv */
// Sample bank and slot grant interfaces.
interface bank_if;
	// One slot per stream, with its full flag.
	logic [smux_pkg::NUM_STREAMS-1:0] full;
	logic [smux_pkg::NUM_STREAMS-1:0][smux_pkg::SAMPLE_W-1:0] samples;
	// Clears the slot at pop_index.
	logic pop;
	logic [smux_pkg::IDX_W-1:0] pop_index;

	modport holder (output full, output samples, input pop, input pop_index);
	modport reader (input samples, output pop, output pop_index);
	modport viewer (input full);
endinterface

interface grant_if;
	// Current owner of the output.
	logic grant_valid;
	logic grant_at;
	logic [smux_pkg::IDX_W-1:0] grant_index;
	// Pulses once the output ack of a frame has fallen.
	logic word_done;
	// Command FIFO head.
	logic at_empty;
	logic [smux_pkg::AT_W-1:0] at_char;
	logic at_pop;

	modport scheduler (output grant_valid, output grant_at, output grant_index,
		input word_done, input at_empty);
	modport sender (input grant_valid, input grant_at, input grant_index,
		input at_char, output word_done, output at_pop);
	modport cmd_source (output at_empty, output at_char, input at_pop);
endinterface

/* design/smux_pkg.sv */
// Stream counts, widths and FIFO depth for the sensor link multiplexer.
// Tagged 16-bit frame with its data and command views.
package smux_pkg;

	// ----------------------------------------
	// Sizes
	// ----------------------------------------
	localparam int NUM_STREAMS = 8;
	localparam int SAMPLE_W = 12;
	localparam int AT_W = 8;
	localparam int IDX_W = 3;
	localparam int TIMER_W = 10;
	localparam int AT_DEPTH = 8;
	localparam int AT_PTR_W = $clog2(AT_DEPTH);

	// Frame layout. The kind bit selects how the rest is read.
	localparam int FRAME_W = 16;
	localparam int PAD_W = FRAME_W - 1 - AT_W;
	localparam logic KIND_DATA = 1'b0;
	localparam logic KIND_CMD = 1'b1;

	// ----------------------------------------
	// Frame views
	// ----------------------------------------
	// Sample from one stream.
	typedef struct packed
	{
		logic kind;
		logic [IDX_W-1:0] index;
		logic [SAMPLE_W-1:0] sample;
	} data_view_t;

	// AT character, upper bits padded with zeros.
	typedef struct packed
	{
		logic kind;
		logic [PAD_W-1:0] pad;
		logic [AT_W-1:0] character;
	} cmd_view_t;

	typedef union packed
	{
		data_view_t data;
		cmd_view_t cmd;
	} frame_t;

endpackage

/* design/smux_top.sv */
// Stream multiplexer top level.
// Receivers, command FIFO, slot scheduler and frame sender.
module smux_top
(
	input  logic clock,
	input  logic resetn,
	// Sample streams.
	input  logic [smux_pkg::NUM_STREAMS-1:0] stream_req_i,
	input  logic [smux_pkg::NUM_STREAMS-1:0][smux_pkg::SAMPLE_W-1:0] stream_data_i,
	output logic [smux_pkg::NUM_STREAMS-1:0] stream_ack_o,
	// Command channel.
	input  logic at_req_i,
	input  logic [smux_pkg::AT_W-1:0] at_data_i,
	output logic at_ack_o,
	// Control.
	input  logic sending_i,
	input  logic want_at_i,
	input  logic [smux_pkg::NUM_STREAMS-1:0] selected_streams_i,
	input  logic [smux_pkg::TIMER_W-1:0] slot_cycles_i,
	// Output port.
	output logic frame_req_o,
	output logic [smux_pkg::FRAME_W-1:0] frame_o,
	input  logic frame_ack_i
);

	bank_if bank ();
	grant_if grant ();

	stream_inputs u_stream_inputs (
		.clock        (clock),
		.resetn       (resetn),
		.stream_req_i (stream_req_i),
		.stream_data_i(stream_data_i),
		.stream_ack_o (stream_ack_o),
		.bank         (bank.holder)
	);

	at_buffer u_at_buffer (
		.clock    (clock),
		.resetn   (resetn),
		.at_req_i (at_req_i),
		.at_data_i(at_data_i),
		.at_ack_o (at_ack_o),
		.cmd      (grant.cmd_source)
	);

	slot_scheduler u_slot_scheduler (
		.clock             (clock),
		.resetn            (resetn),
		.sending_i         (sending_i),
		.want_at_i         (want_at_i),
		.selected_streams_i(selected_streams_i),
		.slot_cycles_i     (slot_cycles_i),
		.bank              (bank.viewer),
		.grant             (grant.scheduler)
	);

	frame_sender u_frame_sender (
		.clock      (clock),
		.resetn     (resetn),
		.grant      (grant.sender),
		.bank       (bank.reader),
		.frame_req_o(frame_req_o),
		.frame_o    (frame_o),
		.frame_ack_i(frame_ack_i)
	);

endmodule

/* design/stream_inputs.sv */
// Eight four-phase sample receivers with a one-sample slot each.
module stream_inputs
(
	input  logic clock,
	input  logic resetn,
	input  logic [smux_pkg::NUM_STREAMS-1:0] stream_req_i,
	input  logic [smux_pkg::NUM_STREAMS-1:0][smux_pkg::SAMPLE_W-1:0] stream_data_i,
	output logic [smux_pkg::NUM_STREAMS-1:0] stream_ack_o,
	bank_if.holder bank
);

	for (genvar i = 0; i < smux_pkg::NUM_STREAMS; i++)
	begin : g_rx
		logic full_q;
		logic ack_q;
		logic take;
		logic [smux_pkg::SAMPLE_W-1:0] sample_q;

		// A request is taken only into an empty slot, and only once per handshake.
		assign take = stream_req_i[i] && !full_q && !ack_q;

		always_ff @(posedge clock or negedge resetn)
		begin
			if (!resetn)
			begin
				full_q <= 1'b0;
				ack_q <= 1'b0;
			end
			else
			begin
				if (take)
				begin
					full_q <= 1'b1;
				end
				else if (bank.pop && (bank.pop_index == smux_pkg::IDX_W'(i)))
				begin
					full_q <= 1'b0;
				end

				// Ack rises with the take and drops the cycle after req falls.
				if (take)
				begin
					ack_q <= 1'b1;
				end
				else if (!stream_req_i[i])
				begin
					ack_q <= 1'b0;
				end
			end
		end

		always_ff @(posedge clock)
		begin
			if (take)
			begin
				sample_q <= stream_data_i[i];
			end
		end

		assign bank.full[i] = full_q;
		assign bank.samples[i] = sample_q;
		assign stream_ack_o[i] = ack_q;
	end

endmodule

/* src.f */
design/smux_pkg.sv
design/smux_ifs.sv
design/stream_inputs.sv
design/at_buffer.sv
design/slot_scheduler.sv
design/frame_sender.sv
design/smux_top.sv
tb/smux_assertions.sv
tb/tb_smux.sv

/* tb/smux_assertions.sv */
// Frame scoreboards and concurrent assertions for the stream multiplexer.
// Bound to the top level and fed from its ports only.
module smux_assertions
(
	input  logic clock,
	input  logic resetn,
	input  logic [smux_pkg::NUM_STREAMS-1:0] stream_req_i,
	input  logic [smux_pkg::NUM_STREAMS-1:0][smux_pkg::SAMPLE_W-1:0] stream_data_i,
	input  logic [smux_pkg::NUM_STREAMS-1:0] stream_ack_o,
	input  logic at_req_i,
	input  logic [smux_pkg::AT_W-1:0] at_data_i,
	input  logic at_ack_o,
	input  logic sending_i,
	input  logic want_at_i,
	input  logic [smux_pkg::NUM_STREAMS-1:0] selected_streams_i,
	input  logic frame_req_o,
	input  logic [smux_pkg::FRAME_W-1:0] frame_o,
	input  logic frame_ack_i
);

	// Samples and characters accepted but not yet sent, oldest first.
	logic [smux_pkg::SAMPLE_W-1:0] sample_q [smux_pkg::NUM_STREAMS][$];
	logic [smux_pkg::AT_W-1:0] at_q [$];
	logic [smux_pkg::SAMPLE_W-1:0] head [smux_pkg::NUM_STREAMS];
	logic [smux_pkg::NUM_STREAMS-1:0] head_valid;
	logic [smux_pkg::AT_W-1:0] at_head;
	logic at_head_valid;
	logic [smux_pkg::NUM_STREAMS-1:0] ack_q;
	logic at_ack_q;
	logic req_q;
	logic req_seen;
	logic want_seen;
	int error_count;

	smux_pkg::frame_t seen;
	logic [smux_pkg::IDX_W-1:0] idx;
	logic start;
	logic is_data;
	logic is_cmd;
	logic [smux_pkg::FRAME_W-1:0] expected_data;
	logic [smux_pkg::FRAME_W-1:0] expected_cmd;

	initial error_count = 0;

	assign seen = frame_o;
	assign idx = seen.data.index;
	assign start = frame_req_o && !req_q;
	assign is_data = start && (seen.data.kind == smux_pkg::KIND_DATA);
	assign is_cmd = start && (seen.cmd.kind == smux_pkg::KIND_CMD);
	assign expected_data = {smux_pkg::KIND_DATA, idx, head[idx]};
	assign expected_cmd = {smux_pkg::KIND_CMD, {smux_pkg::PAD_W{1'b0}}, at_head};

	// ----------------------------------------
	// Scoreboards
	// ----------------------------------------
	always @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < smux_pkg::NUM_STREAMS; i++)
				sample_q[i].delete();
			at_q.delete();
			head_valid <= '0;
			at_head_valid <= 1'b0;
			ack_q <= '0;
			at_ack_q <= 1'b0;
			req_q <= 1'b0;
			req_seen <= 1'b0;
			want_seen <= 1'b0;
		end
		else
		begin
			// An input is recorded when its ack rises, data still held by req.
			for (int i = 0; i < smux_pkg::NUM_STREAMS; i++)
			begin
				if (stream_ack_o[i] && !ack_q[i])
					sample_q[i].push_back(stream_data_i[i]);
			end
			if (at_ack_o && !at_ack_q)
				at_q.push_back(at_data_i);

			// A frame is retired when its req falls.
			if (!frame_req_o && req_q)
			begin
				if (seen.cmd.kind == smux_pkg::KIND_CMD)
				begin
					if (at_q.size() != 0)
						void'(at_q.pop_front());
				end
				else if (sample_q[idx].size() != 0)
					void'(sample_q[idx].pop_front());
			end

			for (int i = 0; i < smux_pkg::NUM_STREAMS; i++)
			begin
				head_valid[i] <= (sample_q[i].size() != 0);
				head[i] <= (sample_q[i].size() != 0) ? sample_q[i][0] : '0;
			end
			at_head_valid <= (at_q.size() != 0);
			at_head <= (at_q.size() != 0) ? at_q[0] : '0;

			ack_q <= stream_ack_o;
			at_ack_q <= at_ack_o;
			req_q <= frame_req_o;
			if ((stream_req_i != '0) || at_req_i)
				req_seen <= 1'b1;
			if (want_at_i)
				want_seen <= 1'b1;
		end
	end

	// ----------------------------------------
	// Assertions
	// ----------------------------------------
	a_quiet_until_req: assert property (@(posedge clock) disable iff (!resetn)
		!req_seen |-> !frame_req_o && (stream_ack_o == '0) && !at_ack_o)
	else
	begin
		error_count++;
		$error("Output req or an input ack went high at %0t before any input request", $time);
	end

	a_data_source: assert property (@(posedge clock) disable iff (!resetn)
		is_data |-> selected_streams_i[idx] && head_valid[idx])
	else
	begin
		error_count++;
		$error("Data frame at %0t from stream %0d, which is disabled or has no sample",
			$time, idx);
	end

	a_data_value: assert property (@(posedge clock) disable iff (!resetn)
		is_data && head_valid[idx] |-> frame_o == expected_data)
	else
	begin
		error_count++;
		$error("Mismatch at %0t: frame_o expected %h, got %h", $time, expected_data, frame_o);
	end

	a_cmd_source: assert property (@(posedge clock) disable iff (!resetn)
		is_cmd |-> want_seen && at_head_valid && (seen.cmd.pad == '0))
	else
	begin
		error_count++;
		$error("Command frame at %0t before want_at, with no character, or with pad bits set",
			$time);
	end

	a_cmd_value: assert property (@(posedge clock) disable iff (!resetn)
		is_cmd && at_head_valid |-> frame_o == expected_cmd)
	else
	begin
		error_count++;
		$error("Mismatch at %0t: frame_o expected %h, got %h", $time, expected_cmd, frame_o);
	end

	a_frame_stable: assert property (@(posedge clock) disable iff (!resetn)
		frame_req_o && req_q |-> $stable(frame_o))
	else
	begin
		error_count++;
		$error("frame_o changed at %0t while frame_req_o was high", $time);
	end

	a_req_after_ack: assert property (@(posedge clock) disable iff (!resetn)
		$fell(frame_req_o) |-> $past(frame_ack_i))
	else
	begin
		error_count++;
		$error("frame_req_o fell at %0t before frame_ack_i had risen", $time);
	end

	a_no_start_stopped: assert property (@(posedge clock) disable iff (!resetn)
		start |-> $past(sending_i))
	else
	begin
		error_count++;
		$error("A frame started at %0t while sending_i was low", $time);
	end

endmodule

bind smux_top smux_assertions u_checker (
	.clock             (clock),
	.resetn            (resetn),
	.stream_req_i      (stream_req_i),
	.stream_data_i     (stream_data_i),
	.stream_ack_o      (stream_ack_o),
	.at_req_i          (at_req_i),
	.at_data_i         (at_data_i),
	.at_ack_o          (at_ack_o),
	.sending_i         (sending_i),
	.want_at_i         (want_at_i),
	.selected_streams_i(selected_streams_i),
	.frame_req_o       (frame_req_o),
	.frame_o           (frame_o),
	.frame_ack_i       (frame_ack_i)
);

/* tb/tb_smux.sv */
// Testbench for the stream multiplexer.
// Clock, reset, LFSR stimulus, four-phase agents, tests and timeout.
module tb_smux;

	// Cycle budgets of the tests are summed into the run limit.
	localparam int RESET_BUDGET = 50;
	localparam int ROTATION_BUDGET = 2000;
	localparam int COMMAND_BUDGET = 2000;
	localparam int PAUSE_BUDGET = 1500;
	localparam int CYCLE_LIMIT = RESET_BUDGET + ROTATION_BUDGET + COMMAND_BUDGET
		+ PAUSE_BUDGET + 500;

	logic clock;
	logic resetn;
	logic [smux_pkg::NUM_STREAMS-1:0] stream_req;
	logic [smux_pkg::NUM_STREAMS-1:0][smux_pkg::SAMPLE_W-1:0] stream_data;
	logic [smux_pkg::NUM_STREAMS-1:0] stream_ack;
	logic at_req;
	logic [smux_pkg::AT_W-1:0] at_data;
	logic at_ack;
	logic sending;
	logic want_at;
	logic [smux_pkg::NUM_STREAMS-1:0] selected;
	logic [smux_pkg::TIMER_W-1:0] slot_cycles;
	logic frame_req;
	logic [smux_pkg::FRAME_W-1:0] frame;
	logic frame_ack;

	logic [15:0] stimulus_lfsr = 16'd46;
	logic [15:0] delay_lfsr = 16'd46;
	int cycle_count = 0;
	int items_sent = 0;
	int frames_received = 0;
	int tests_failed = 0;
	int errors_before = 0;

	smux_top uut (
		.clock             (clock),
		.resetn            (resetn),
		.stream_req_i      (stream_req),
		.stream_data_i     (stream_data),
		.stream_ack_o      (stream_ack),
		.at_req_i          (at_req),
		.at_data_i         (at_data),
		.at_ack_o          (at_ack),
		.sending_i         (sending),
		.want_at_i         (want_at),
		.selected_streams_i(selected),
		.slot_cycles_i     (slot_cycles),
		.frame_req_o       (frame_req),
		.frame_o           (frame),
		.frame_ack_i       (frame_ack)
	);

	// ----------------------------------------
	// Clock, random source and timeout
	// ----------------------------------------
	always #5 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: no result after %0d cycles, the run stopped making progress",
				cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// Galois LFSR stepped once for each bit taken.
	function automatic logic [15:0] take_bits(inout logic [15:0] state, input int count);
		logic [15:0] value;
		value = '0;
		for (int k = 0; k < count; k++)
		begin
			value = {value[14:0], state[0]};
			if (state[0])
				state = (state >> 1) ^ 16'hB400;
			else
				state = state >> 1;
		end
		return value;
	endfunction

	// Inputs change and outputs are read 1 unit after the rising edge.
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	// ----------------------------------------
	// Four-phase agents
	// ----------------------------------------
	task automatic send_sample(input int stream);
		logic [15:0] value;
		value = take_bits(stimulus_lfsr, smux_pkg::SAMPLE_W);
		stream_data[stream] = value[smux_pkg::SAMPLE_W-1:0];
		stream_req[stream] = 1'b1;
		do
			next_cycle();
		while (!stream_ack[stream]);
		items_sent++;
		stream_req[stream] = 1'b0;
		do
			next_cycle();
		while (stream_ack[stream]);
	endtask

	task automatic send_char();
		logic [15:0] value;
		value = take_bits(stimulus_lfsr, smux_pkg::AT_W);
		at_data = value[smux_pkg::AT_W-1:0];
		at_req = 1'b1;
		do
			next_cycle();
		while (!at_ack);
		items_sent++;
		at_req = 1'b0;
		do
			next_cycle();
		while (at_ack);
	endtask

	// Output side answers every frame after a random delay of 0 to 3 cycles.
	initial
	begin : output_agent
		int delay;
		frame_ack = 1'b0;
		forever
		begin
			next_cycle();
			if (frame_req)
			begin
				delay = int'(take_bits(delay_lfsr, 2));
				repeat (delay) next_cycle();
				frame_ack = 1'b1;
				do
					next_cycle();
				while (frame_req);
				delay = int'(take_bits(delay_lfsr, 2));
				repeat (delay) next_cycle();
				frame_ack = 1'b0;
				frames_received++;
			end
		end
	end

	task automatic wait_frames(input int count);
		while (frames_received < count)
			next_cycle();
	endtask

	task automatic wait_drained();
		wait_frames(items_sent);
	endtask

	task automatic report_test(input int number, input string name);
		int errors;
		errors = uut.u_checker.error_count - errors_before;
		if (errors != 0)
			tests_failed++;
		$display("Test %0d %s: %s, %0d assertion errors", number, name,
			(errors == 0) ? "ok" : "failed", errors);
		errors_before = uut.u_checker.error_count;
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	initial
	begin
		clock = 1'b0;
		resetn = 1'b0;
		stream_req = '0;
		stream_data = '0;
		at_req = 1'b0;
		at_data = '0;
		sending = 1'b0;
		want_at = 1'b0;
		selected = '0;
		slot_cycles = '0;
		repeat (3) @(posedge clock);
		#1;
		resetn = 1'b1;

		// Scheduler runs over empty slots. Nothing may move before the first request.
		selected = 8'b1011_0101;
		slot_cycles = 10'd3;
		sending = 1'b1;
		repeat (20) next_cycle();
		report_test(1, "reset idle");

		// Three rounds over five enabled streams with back-pressure.
		for (int r = 0; r < 3; r++)
		begin
			for (int s = 0; s < smux_pkg::NUM_STREAMS; s++)
			begin
				if (selected[s])
					send_sample(s);
			end
		end
		wait_drained();
		report_test(2, "rotation");

		// A character waits while command mode is not wanted.
		send_char();
		repeat (40) next_cycle();

		// Characters mixed with samples while command mode is wanted.
		want_at = 1'b1;
		for (int c = 0; c < 10; c++)
		begin
			send_char();
			if (c % 3 == 0)
				send_sample(0);
		end
		wait_drained();
		want_at = 1'b0;
		report_test(3, "commands");

		// Fill every slot while stopped.
		sending = 1'b0;
		repeat (30) next_cycle();
		for (int s = 0; s < smux_pkg::NUM_STREAMS; s++)
			send_sample(s);
		repeat (20) next_cycle();

		// Resume with half the streams enabled, then with all of them.
		selected = 8'b0110_1001;
		slot_cycles = 10'd1;
		sending = 1'b1;
		wait_frames(items_sent - (smux_pkg::NUM_STREAMS - $countones(selected)));
		selected = 8'hFF;
		wait_drained();
		report_test(4, "pause and resume");

		$display("Tests run: 4, failed: %0d, frames: %0d, assertion errors: %0d",
			tests_failed, frames_received, uut.u_checker.error_count);
		if (tests_failed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
